// File: filelist.f
+incdir+hdl
hdl/remap_pkg.sv
hdl/lowest_set_finder.sv
hdl/id_remap_table.sv
hdl/ax_id_assigner.sv
hdl/remap_direction.sv
hdl/axi_id_remap.sv
bench/tb_axi_id_remap.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  -f filelist.f --top-module tb_axi_id_remap -o tb_axi_id_remap

./obj_dir/tb_axi_id_remap > sim.log 2>&1 || true
cat sim.log

# The run passes only if the testbench printed its pass message.
grep -q "^Test passed$" sim.log

// File: bench/tb_axi_id_remap.sv
`timescale 1ns/10ps
`default_nettype none

`include "remap_settings.svh"

module tb_axi_id_remap
  import remap_pkg::*;
();

  localparam int N_ENTRIES      = `REMAP_MAX_UNIQ_IDS;
  localparam int TIMEOUT_CYCLES = 50;
  // Direction selectors for the shared tasks.
  localparam int RD = 0;
  localparam int WR = 1;

  logic    clk_i;
  logic    rst_i;

  logic    slv_ar_valid_i;
  slv_id_t slv_ar_id_i;
  addr_t   slv_ar_addr_i;
  len_t    slv_ar_len_i;
  logic    slv_ar_ready_o;
  logic    slv_aw_valid_i;
  slv_id_t slv_aw_id_i;
  addr_t   slv_aw_addr_i;
  len_t    slv_aw_len_i;
  logic    slv_aw_ready_o;
  logic    slv_w_valid_i;
  data_t   slv_w_data_i;
  strb_t   slv_w_strb_i;
  logic    slv_w_last_i;
  logic    slv_w_ready_o;
  logic    slv_r_valid_o;
  slv_id_t slv_r_id_o;
  data_t   slv_r_data_o;
  resp_t   slv_r_resp_o;
  logic    slv_r_last_o;
  logic    slv_r_ready_i;
  logic    slv_b_valid_o;
  slv_id_t slv_b_id_o;
  resp_t   slv_b_resp_o;
  logic    slv_b_ready_i;

  logic    mst_ar_valid_o;
  mst_id_t mst_ar_id_o;
  addr_t   mst_ar_addr_o;
  len_t    mst_ar_len_o;
  logic    mst_ar_ready_i;
  logic    mst_aw_valid_o;
  mst_id_t mst_aw_id_o;
  addr_t   mst_aw_addr_o;
  len_t    mst_aw_len_o;
  logic    mst_aw_ready_i;
  logic    mst_w_valid_o;
  data_t   mst_w_data_o;
  strb_t   mst_w_strb_o;
  logic    mst_w_last_o;
  logic    mst_w_ready_i;
  logic    mst_r_valid_i;
  mst_id_t mst_r_id_i;
  data_t   mst_r_data_i;
  resp_t   mst_r_resp_i;
  logic    mst_r_last_i;
  logic    mst_r_ready_o;
  logic    mst_b_valid_i;
  mst_id_t mst_b_id_i;
  resp_t   mst_b_resp_i;
  logic    mst_b_ready_o;

  int checks;
  int errors;
  bit timed_out;

  // Reference table per direction, indexed by the narrow ID.
  slv_id_t ref_id  [2][N_ENTRIES];
  int      ref_cnt [2][N_ENTRIES];

  logic [31:0] rand_state = 32'h420f_f8ee;

  axi_id_remap axi_id_remap_i (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Linear congruential generator for addresses, lengths, data and responses.
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // A known ID in flight keeps its entry. A new ID takes the lowest free entry.
  function automatic idx_t ref_index(input int dir, input slv_id_t id);
    idx_t idx;
    idx = '0;
    for (int i = N_ENTRIES - 1; i >= 0; i--) begin
      if (ref_cnt[dir][i] == 0) begin
        idx = idx_t'(i);
      end
    end
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (ref_cnt[dir][i] != 0 && ref_id[dir][i] == id) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

  task automatic check_slv_id(input string what, input slv_id_t got, input slv_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_mst_id(input string what, input mst_id_t got, input mst_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input string what, input len_t got, input len_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_strb(input string what, input strb_t got, input strb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input resp_t got, input resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic drive_ax(input int dir, input logic valid, input slv_id_t id,
                          input addr_t addr, input len_t len);
    if (dir == RD) begin
      slv_ar_valid_i = valid;
      slv_ar_id_i    = id;
      slv_ar_addr_i  = addr;
      slv_ar_len_i   = len;
    end else begin
      slv_aw_valid_i = valid;
      slv_aw_id_i    = id;
      slv_aw_addr_i  = addr;
      slv_aw_len_i   = len;
    end
  endtask

  task automatic sample_ax(input int dir, output logic slv_rdy, output logic mst_vld,
                           output mst_id_t id, output addr_t addr, output len_t len);
    if (dir == RD) begin
      slv_rdy = slv_ar_ready_o;
      mst_vld = mst_ar_valid_o;
      id      = mst_ar_id_o;
      addr    = mst_ar_addr_o;
      len     = mst_ar_len_o;
    end else begin
      slv_rdy = slv_aw_ready_o;
      mst_vld = mst_aw_valid_o;
      id      = mst_aw_id_o;
      addr    = mst_aw_addr_o;
      len     = mst_aw_len_o;
    end
  endtask

  // Waits for the upstream handshake of a request that is already driven.
  // The downstream ID is the expected index, zero-extended.
  task automatic wait_ax_accept(input int dir, input slv_id_t id, input addr_t addr,
                                input len_t len);
    logic    rdy;
    logic    vld;
    mst_id_t got_id;
    addr_t   got_addr;
    len_t    got_len;
    idx_t    exp_idx;
    bit      done;
    int      cycles;
    done   = 1'b0;
    cycles = 0;
    while (!done && !timed_out) begin
      #5;
      sample_ax(dir, rdy, vld, got_id, got_addr, got_len);
      if (rdy) begin
        exp_idx = ref_index(dir, id);
        check_flag("downstream request valid", vld, 1'b1);
        check_mst_id("downstream request ID", got_id, mst_id_t'(exp_idx));
        check_addr("downstream address", got_addr, addr);
        check_len("downstream length", got_len, len);
        ref_id[dir][exp_idx]  = id;
        ref_cnt[dir][exp_idx] = ref_cnt[dir][exp_idx] + 1;
        done = 1'b1;
      end
      @(negedge clk_i);
      cycles++;
      if (!done && cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the %s request with ID %0d was never accepted",
                 (dir == RD) ? "AR" : "AW", id);
        errors++;
        timed_out = 1'b1;
      end
    end
    drive_ax(dir, 1'b0, '0, '0, '0);
  endtask

  task automatic send_ax(input int dir, input slv_id_t id);
    addr_t addr;
    len_t  len;
    addr = next_rand();
    len  = len_t'(next_rand());
    drive_ax(dir, 1'b1, id, addr, len);
    wait_ax_accept(dir, id, addr, len);
  endtask

  // One response beat from downstream. Upstream ready is always high here.
  // Every B and each R with last releases one count of the entry.
  task automatic send_rsp(input int dir, input mst_id_t id, input logic last);
    data_t   data;
    resp_t   resp;
    idx_t    idx;
    slv_id_t exp_id;
    data   = next_rand();
    resp   = resp_t'(next_rand());
    idx    = id[`REMAP_IDX_WIDTH-1:0];
    exp_id = ref_id[dir][idx];
    if (dir == RD) begin
      mst_r_valid_i = 1'b1;
      mst_r_id_i    = id;
      mst_r_data_i  = data;
      mst_r_resp_i  = resp;
      mst_r_last_i  = last;
      #5;
      check_flag("slv_r_valid_o", slv_r_valid_o, 1'b1);
      check_slv_id("slv_r_id_o", slv_r_id_o, exp_id);
      check_data("slv_r_data_o", slv_r_data_o, data);
      check_resp("slv_r_resp_o", slv_r_resp_o, resp);
      check_flag("slv_r_last_o", slv_r_last_o, last);
      check_flag("mst_r_ready_o", mst_r_ready_o, 1'b1);
    end else begin
      mst_b_valid_i = 1'b1;
      mst_b_id_i    = id;
      mst_b_resp_i  = resp;
      #5;
      check_flag("slv_b_valid_o", slv_b_valid_o, 1'b1);
      check_slv_id("slv_b_id_o", slv_b_id_o, exp_id);
      check_resp("slv_b_resp_o", slv_b_resp_o, resp);
      check_flag("mst_b_ready_o", mst_b_ready_o, 1'b1);
    end
    @(negedge clk_i);
    mst_r_valid_i = 1'b0;
    mst_r_last_i  = 1'b0;
    mst_b_valid_i = 1'b0;
    if (dir == WR || last) begin
      ref_cnt[dir][idx] = ref_cnt[dir][idx] - 1;
    end
  endtask

  // The request must stay blocked until a response frees room for it.
  task automatic stall_then_release(input int dir, input slv_id_t id, input mst_id_t rel_id);
    addr_t   addr;
    len_t    len;
    logic    rdy;
    logic    vld;
    mst_id_t got_id;
    addr_t   got_addr;
    len_t    got_len;
    addr = next_rand();
    len  = len_t'(next_rand());
    drive_ax(dir, 1'b1, id, addr, len);
    repeat (4) begin
      #5;
      sample_ax(dir, rdy, vld, got_id, got_addr, got_len);
      check_flag("upstream ready of a blocked request", rdy, 1'b0);
      check_flag("downstream valid of a blocked request", vld, 1'b0);
      @(negedge clk_i);
    end
    send_rsp(dir, rel_id, 1'b1);
    wait_ax_accept(dir, id, addr, len);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("[%s] ok", name);
    end else begin
      $display("[%s] %0d error(s)", name, errors - err_before);
    end
  endtask

  task automatic test_assignment();
    int err0;
    err0 = errors;
    #5;
    check_flag("mst_ar_valid_o after reset", mst_ar_valid_o, 1'b0);
    check_flag("mst_aw_valid_o after reset", mst_aw_valid_o, 1'b0);
    @(negedge clk_i);
    send_ax(RD, 6'd5);
    send_ax(RD, 6'd9);
    send_ax(RD, 6'd5);
    // The write table starts empty, so ID 9 takes entry 0 there.
    send_ax(WR, 6'd9);
    report_test("assignment", err0);
  endtask

  task automatic test_response();
    int    err0;
    data_t data;
    strb_t strb;
    err0 = errors;
    // With no beat pending, valid stays low and each ready follows the far side.
    slv_r_ready_i = 1'b0;
    slv_b_ready_i = 1'b0;
    mst_w_ready_i = 1'b0;
    #5;
    check_flag("slv_r_valid_o while idle", slv_r_valid_o, 1'b0);
    check_flag("slv_b_valid_o while idle", slv_b_valid_o, 1'b0);
    check_flag("mst_w_valid_o while idle", mst_w_valid_o, 1'b0);
    check_flag("mst_r_ready_o with upstream stalled", mst_r_ready_o, 1'b0);
    check_flag("mst_b_ready_o with upstream stalled", mst_b_ready_o, 1'b0);
    check_flag("slv_w_ready_o with downstream stalled", slv_w_ready_o, 1'b0);
    @(negedge clk_i);
    slv_r_ready_i = 1'b1;
    slv_b_ready_i = 1'b1;
    mst_w_ready_i = 1'b1;
    // A beat without last keeps entry 1 busy, so a new ID lands in entry 2.
    send_rsp(RD, 3'd1, 1'b0);
    send_ax(RD, 6'd12);
    send_rsp(RD, 3'd1, 1'b1);
    data = next_rand();
    strb = strb_t'(next_rand());
    slv_w_valid_i = 1'b1;
    slv_w_data_i  = data;
    slv_w_strb_i  = strb;
    slv_w_last_i  = 1'b1;
    #5;
    check_flag("mst_w_valid_o", mst_w_valid_o, 1'b1);
    check_data("mst_w_data_o", mst_w_data_o, data);
    check_strb("mst_w_strb_o", mst_w_strb_o, strb);
    check_flag("mst_w_last_o", mst_w_last_o, 1'b1);
    check_flag("slv_w_ready_o", slv_w_ready_o, 1'b1);
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
    slv_w_last_i  = 1'b0;
    send_rsp(WR, 3'd0, 1'b0);
    report_test("response restore", err0);
  endtask

  task automatic test_per_id_limit();
    int err0;
    err0 = errors;
    repeat (3) begin
      send_ax(RD, 6'd33);
    end
    stall_then_release(RD, 6'd33, 3'd1);
    report_test("per-ID limit", err0);
  endtask

  task automatic test_table_full();
    int err0;
    err0 = errors;
    send_ax(WR, 6'd1);
    send_ax(WR, 6'd2);
    send_ax(WR, 6'd3);
    send_ax(WR, 6'd4);
    stall_then_release(WR, 6'd7, 3'd2);
    report_test("table full", err0);
  endtask

  task automatic test_back_pressure();
    int    err0;
    idx_t  exp_idx;
    addr_t addr;
    len_t  len;
    err0    = errors;
    exp_idx = ref_index(RD, 6'd40);
    addr    = next_rand();
    len     = len_t'(next_rand());
    mst_ar_ready_i = 1'b0;
    drive_ax(RD, 1'b1, 6'd40, addr, len);
    repeat (3) begin
      #5;
      check_flag("mst_ar_valid_o under back-pressure", mst_ar_valid_o, 1'b1);
      check_mst_id("mst_ar_id_o under back-pressure", mst_ar_id_o, mst_id_t'(exp_idx));
      check_flag("slv_ar_ready_o under back-pressure", slv_ar_ready_o, 1'b0);
      @(negedge clk_i);
    end
    mst_ar_ready_i = 1'b1;
    wait_ax_accept(RD, 6'd40, addr, len);
    #5;
    check_flag("mst_ar_valid_o after the held transfer", mst_ar_valid_o, 1'b0);
    @(negedge clk_i);
    // Two more fit only if the held request was counted once.
    send_ax(RD, 6'd40);
    send_ax(RD, 6'd40);
    stall_then_release(RD, 6'd40, 3'd3);
    report_test("back-pressure", err0);
  endtask

  initial begin
    rst_i          = 1'b1;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_r_ready_i  = 1'b1;
    slv_b_ready_i  = 1'b1;
    mst_ar_ready_i = 1'b1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    checks         = 0;
    errors         = 0;
    timed_out      = 1'b0;
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        ref_id[d][i]  = '0;
        ref_cnt[d][i] = 0;
      end
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    if (!timed_out) test_assignment();
    if (!timed_out) test_response();
    if (!timed_out) test_per_id_limit();
    if (!timed_out) test_table_full();
    if (!timed_out) test_back_pressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/axi_id_remap.sv
`timescale 1ns/10ps
`default_nettype none

module axi_id_remap
  import remap_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,

  // Upstream port with wide IDs.
  input  wire logic    slv_ar_valid_i,
  input  wire slv_id_t slv_ar_id_i,
  input  wire addr_t   slv_ar_addr_i,
  input  wire len_t    slv_ar_len_i,
  output logic         slv_ar_ready_o,

  input  wire logic    slv_aw_valid_i,
  input  wire slv_id_t slv_aw_id_i,
  input  wire addr_t   slv_aw_addr_i,
  input  wire len_t    slv_aw_len_i,
  output logic         slv_aw_ready_o,

  input  wire logic    slv_w_valid_i,
  input  wire data_t   slv_w_data_i,
  input  wire strb_t   slv_w_strb_i,
  input  wire logic    slv_w_last_i,
  output logic         slv_w_ready_o,

  output logic         slv_r_valid_o,
  output slv_id_t      slv_r_id_o,
  output data_t        slv_r_data_o,
  output resp_t        slv_r_resp_o,
  output logic         slv_r_last_o,
  input  wire logic    slv_r_ready_i,

  output logic         slv_b_valid_o,
  output slv_id_t      slv_b_id_o,
  output resp_t        slv_b_resp_o,
  input  wire logic    slv_b_ready_i,

  // Downstream port with narrow IDs.
  output logic         mst_ar_valid_o,
  output mst_id_t      mst_ar_id_o,
  output addr_t        mst_ar_addr_o,
  output len_t         mst_ar_len_o,
  input  wire logic    mst_ar_ready_i,

  output logic         mst_aw_valid_o,
  output mst_id_t      mst_aw_id_o,
  output addr_t        mst_aw_addr_o,
  output len_t         mst_aw_len_o,
  input  wire logic    mst_aw_ready_i,

  output logic         mst_w_valid_o,
  output data_t        mst_w_data_o,
  output strb_t        mst_w_strb_o,
  output logic         mst_w_last_o,
  input  wire logic    mst_w_ready_i,

  input  wire logic    mst_r_valid_i,
  input  wire mst_id_t mst_r_id_i,
  input  wire data_t   mst_r_data_i,
  input  wire resp_t   mst_r_resp_i,
  input  wire logic    mst_r_last_i,
  output logic         mst_r_ready_o,

  input  wire logic    mst_b_valid_i,
  input  wire mst_id_t mst_b_id_i,
  input  wire resp_t   mst_b_resp_i,
  output logic         mst_b_ready_o
);

  logic b_done;

  // Address and length travel with the request and are never touched.
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;

  // W carries no ID, so the whole channel passes straight through.
  assign mst_w_valid_o = slv_w_valid_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_strb_o  = slv_w_strb_i;
  assign mst_w_last_o  = slv_w_last_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Responses keep their handshake and payload; only the ID is restored.
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;

  // Every B ends a burst, so the write side treats each handshake as last.
  assign b_done = mst_b_valid_i && slv_b_ready_i;

  remap_direction #(
    .POP_ON_LAST (1'b1)
  ) u_rd_dir (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slv_valid_i  (slv_ar_valid_i),
    .slv_ready_o  (slv_ar_ready_o),
    .slv_id_i     (slv_ar_id_i),
    .mst_valid_o  (mst_ar_valid_o),
    .mst_ready_i  (mst_ar_ready_i),
    .mst_id_o     (mst_ar_id_o),
    .rsp_valid_i  (mst_r_valid_i),
    .rsp_ready_i  (slv_r_ready_i),
    .rsp_last_i   (mst_r_last_i),
    .rsp_mst_id_i (mst_r_id_i),
    .rsp_slv_id_o (slv_r_id_o)
  );

  remap_direction #(
    .POP_ON_LAST (1'b0)
  ) u_wr_dir (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slv_valid_i  (slv_aw_valid_i),
    .slv_ready_o  (slv_aw_ready_o),
    .slv_id_i     (slv_aw_id_i),
    .mst_valid_o  (mst_aw_valid_o),
    .mst_ready_i  (mst_aw_ready_i),
    .mst_id_o     (mst_aw_id_o),
    .rsp_valid_i  (mst_b_valid_i),
    .rsp_ready_i  (slv_b_ready_i),
    .rsp_last_i   (b_done),
    .rsp_mst_id_i (mst_b_id_i),
    .rsp_slv_id_o (slv_b_id_o)
  );

endmodule

`default_nettype wire

// File: hdl/remap_direction.sv
`timescale 1ns/10ps
`default_nettype none

`include "remap_settings.svh"

module remap_direction
  import remap_pkg::*;
#(
  // Reads free an entry only on the last R beat, writes on every B.
  parameter bit POP_ON_LAST = 1'b1
) (
  input  wire logic    clk_i,
  input  wire logic    rst_i,

  // Address channel.
  input  wire logic    slv_valid_i,
  output logic         slv_ready_o,
  input  wire slv_id_t slv_id_i,
  output logic         mst_valid_o,
  input  wire logic    mst_ready_i,
  output mst_id_t      mst_id_o,

  // Response channel.
  input  wire logic    rsp_valid_i,
  input  wire logic    rsp_ready_i,
  input  wire logic    rsp_last_i,
  input  wire mst_id_t rsp_mst_id_i,
  output slv_id_t      rsp_slv_id_o
);

  localparam int unsigned ZERO_W = `REMAP_MST_ID_WIDTH - `REMAP_IDX_WIDTH;

  logic exists;
  logic exists_full;
  logic full;
  idx_t exists_oup_id;
  idx_t free_oup_id;
  logic push;
  idx_t oup_id;
  logic pop;
  idx_t pop_oup_id;

  // The downstream ID is the table index with zeros on top.
  assign mst_id_o = {{ZERO_W{1'b0}}, oup_id};

  // One count is released per completed transaction.
  assign pop = rsp_valid_i && rsp_ready_i && (POP_ON_LAST ? rsp_last_i : 1'b1);

  // Downstream only ever sees zero-extended indices.
  // The low bits of a response ID therefore select the entry.
  assign pop_oup_id = rsp_mst_id_i[`REMAP_IDX_WIDTH-1:0];

  id_remap_table u_table (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ax_id_i         (slv_id_i),
    .exists_o        (exists),
    .exists_oup_id_o (exists_oup_id),
    .exists_full_o   (exists_full),
    .full_o          (full),
    .free_oup_id_o   (free_oup_id),
    .push_i          (push),
    .push_oup_id_i   (oup_id),
    .pop_i           (pop),
    .pop_oup_id_i    (pop_oup_id),
    .pop_inp_id_o    (rsp_slv_id_o)
  );

  ax_id_assigner u_assigner (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .slv_valid_i     (slv_valid_i),
    .slv_ready_o     (slv_ready_o),
    .mst_valid_o     (mst_valid_o),
    .mst_ready_i     (mst_ready_i),
    .exists_i        (exists),
    .exists_full_i   (exists_full),
    .full_i          (full),
    .exists_oup_id_i (exists_oup_id),
    .free_oup_id_i   (free_oup_id),
    .push_o          (push),
    .oup_id_o        (oup_id)
  );

endmodule

`default_nettype wire

// File: hdl/ax_id_assigner.sv
`timescale 1ns/10ps
`default_nettype none

module ax_id_assigner
  import remap_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_i,

  // Upstream and downstream handshakes of the address channel.
  input  wire logic slv_valid_i,
  output logic      slv_ready_o,
  output logic      mst_valid_o,
  input  wire logic mst_ready_i,

  // Lookup results from the table.
  input  wire logic exists_i,
  input  wire logic exists_full_i,
  input  wire logic full_i,
  input  wire idx_t exists_oup_id_i,
  input  wire idx_t free_oup_id_i,

  // Push of the forwarded request into the table.
  output logic      push_o,
  output idx_t      oup_id_o
);

  assign_state_e state_q;
  assign_state_e state_d;
  idx_t          held_idx_q;
  idx_t          held_idx_d;
  logic          may_proceed;
  idx_t          pick_idx;

  // A known ID may proceed below its limit, and a new ID needs a free entry.
  assign may_proceed = exists_i ? !exists_full_i : !full_i;

  // A known ID keeps its entry, which keeps responses of one ID in order.
  assign pick_idx = exists_i ? exists_oup_id_i : free_oup_id_i;

  always_comb begin
    state_d     = state_q;
    held_idx_d  = held_idx_q;
    slv_ready_o = 1'b0;
    mst_valid_o = 1'b0;
    push_o      = 1'b0;
    oup_id_o    = pick_idx;

    case (state_q)
      IDLE: begin
        if (slv_valid_i && may_proceed) begin
          mst_valid_o = 1'b1;
          slv_ready_o = mst_ready_i;
          // The entry is taken now, even if downstream stalls.
          // That way the count covers the request while it is held.
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            held_idx_d = pick_idx;
            state_d    = HOLD;
          end
        end
      end

      HOLD: begin
        // The request is already in the table, so nothing is pushed here.
        mst_valid_o = 1'b1;
        slv_ready_o = mst_ready_i;
        oup_id_o    = held_idx_q;
        if (mst_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      held_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      held_idx_q <= held_idx_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/id_remap_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "remap_settings.svh"

module id_remap_table
  import remap_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_i,

  // Lookup of the upstream ID of the current request.
  input  wire slv_id_t ax_id_i,
  output logic         exists_o,
  output idx_t         exists_oup_id_o,
  output logic         exists_full_o,
  output logic         full_o,
  output idx_t         free_oup_id_o,

  // Push of the current request into an entry.
  input  wire logic    push_i,
  input  wire idx_t    push_oup_id_i,

  // Pop of one completed transaction.
  input  wire logic    pop_i,
  input  wire idx_t    pop_oup_id_i,
  output slv_id_t      pop_inp_id_o
);

  localparam int unsigned N_ENTRIES = `REMAP_MAX_UNIQ_IDS;

  // The table is indexed by the narrow output ID.
  // Each entry holds the upstream ID and its count of transactions in flight.
  slv_id_t inp_id_q [N_ENTRIES];
  cnt_t    cnt_q    [N_ENTRIES];

  field_t  free;
  field_t  match;
  logic    no_match;

  for (genvar i = 0; i < N_ENTRIES; i++) begin : gen_entry
    logic push_hit;
    logic pop_hit;

    // An entry with a zero count is free, whatever ID it still holds.
    assign free[i]  = (cnt_q[i] == '0);
    assign match[i] = (cnt_q[i] != '0) && (inp_id_q[i] == ax_id_i);

    assign push_hit = push_i && (push_oup_id_i == idx_t'(i));
    assign pop_hit  = pop_i && (pop_oup_id_i == idx_t'(i));

    // A push and a pop on the same entry cancel out.
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q[i] <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_q[i] <= cnt_q[i] - cnt_t'(1);
      end
    end

    // The upstream ID is only meaningful while the count is nonzero.
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        inp_id_q[i] <= ax_id_i;
      end
    end
  end

  // Lowest free entry for a new upstream ID.
  // The table is full when no entry is free.
  lowest_set_finder #(
    .WIDTH (N_ENTRIES)
  ) u_free_finder (
    .in_i    (free),
    .idx_o   (free_oup_id_o),
    .empty_o (full_o)
  );

  // At most one entry matches, since a known ID always reuses its entry.
  lowest_set_finder #(
    .WIDTH (N_ENTRIES)
  ) u_match_finder (
    .in_i    (match),
    .idx_o   (exists_oup_id_o),
    .empty_o (no_match)
  );

  assign exists_o = ~no_match;

  // The ID may take no more transactions once its count reaches the limit.
  assign exists_full_o = (cnt_q[exists_oup_id_o] == cnt_t'(`REMAP_MAX_TXNS_PER_ID));

  // Responses look up the upstream ID of their entry.
  assign pop_inp_id_o = inp_id_q[pop_oup_id_i];

endmodule

`default_nettype wire

// File: hdl/lowest_set_finder.sv
`timescale 1ns/10ps
`default_nettype none

module lowest_set_finder #(
  parameter int unsigned WIDTH = 4,
  localparam int unsigned IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  wire logic [WIDTH-1:0] in_i,
  output logic      [IDX_W-1:0] idx_o,
  output logic                  empty_o
);

  // The search runs from the top bit down.
  // A later hit overwrites an earlier one, so the lowest set bit wins.
  always_comb begin
    idx_o = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        idx_o = IDX_W'(i);
      end
    end
  end

  // With no bit set the index stays at zero and must be ignored.
  assign empty_o = ~|in_i;

endmodule

`default_nettype wire

// File: hdl/remap_pkg.sv
`default_nettype none

package remap_pkg;

  `include "remap_settings.svh"

  // ID types on both sides of the remapper.
  typedef logic [`REMAP_SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [`REMAP_MST_ID_WIDTH-1:0] mst_id_t;

  // A table index is the narrow ID before zero-extension.
  typedef logic [`REMAP_IDX_WIDTH-1:0]    idx_t;
  // One bit for each table entry.
  typedef logic [`REMAP_MAX_UNIQ_IDS-1:0] field_t;
  typedef logic [`REMAP_CNT_WIDTH-1:0]    cnt_t;

  // Pass-through payload.
  typedef logic [`REMAP_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`REMAP_DATA_WIDTH-1:0]   data_t;
  typedef logic [`REMAP_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`REMAP_LEN_WIDTH-1:0]    len_t;
  typedef logic [1:0]                     resp_t;

  // States of the address-channel assigner.
  // HOLD keeps a forwarded request on the bus while downstream stalls it.
  typedef enum logic {
    IDLE,
    HOLD
  } assign_state_e;

endpackage

`default_nettype wire

// File: hdl/remap_settings.svh
`ifndef REMAP_SETTINGS_SVH
`define REMAP_SETTINGS_SVH

// Upstream IDs are wide and sparsely used.
`define REMAP_SLV_ID_WIDTH 6

// Downstream IDs are narrow and densely used.
// They must be at least as wide as a table index.
`define REMAP_MST_ID_WIDTH 3

// Each direction tracks this many distinct upstream IDs at once.
`define REMAP_MAX_UNIQ_IDS 4
`define REMAP_IDX_WIDTH 2

// Limit of transactions in flight for one upstream ID.
// The counter must be able to hold zero up to this limit.
`define REMAP_MAX_TXNS_PER_ID 3
`define REMAP_CNT_WIDTH 2

// Payload widths that pass through the remapper unchanged.
`define REMAP_ADDR_WIDTH 32
`define REMAP_DATA_WIDTH 32
`define REMAP_LEN_WIDTH 8

`endif
